//--- list.f
source/shift_types_pkg.sv
source/shift_ctrl_pkg.sv
source/log_barrel_shifter.sv
source/result_fifo.sv
source/credit_counter.sv
source/issue_fsm.sv
source/shift_unit_top.sv
verification/shift_checker.sv
verification/tb_shift_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the shift unit testbench with Verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

rm -rf "$BUILD_DIR" "$LOG_FILE"

verilator --binary --timing -Wno-fatal \
    --top-module tb_shift_unit \
    -Mdir "$BUILD_DIR" \
    -f list.f

"./$BUILD_DIR/Vtb_shift_unit" 2>&1 | tee "$LOG_FILE"

# Result is decided by the log, not by the exit code
if grep -qx "Simulation completed successfully" "$LOG_FILE"; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see $LOG_FILE"
    exit 1
fi

//--- source/credit_counter.sv
// Credit counter, tracks result FIFO slots not yet claimed by issued commands
`timescale 1ns/1ns

module credit_counter #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic clk,
    input  logic rst_n,
    input  logic take,
    input  logic give,
    output logic has_credit,
    output logic all_free
);
    localparam shift_ctrl_pkg::credit_t FULL = shift_ctrl_pkg::credit_t'(FIFO_DEPTH);

    // Free slots, counting commands still in the shifter as used
    shift_ctrl_pkg::credit_t credit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit <= FULL;
        end else begin
            case ({take, give})
                2'b10:   credit <= credit - 1'b1;  // Command accepted
                2'b01:   credit <= credit + 1'b1;  // Result popped
                default: credit <= credit;
            endcase
        end
    end

    assign has_credit = (credit != '0);
    // Nothing in the shifter and nothing in the FIFO
    assign all_free   = (credit == FULL);

endmodule

//--- source/issue_fsm.sv
// Issue FSM, opens the command port and runs the flush handshake
`timescale 1ns/1ns

module issue_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic flush,
    input  logic has_credit,
    input  logic all_free,
    output logic in_ready,
    output logic flush_done
);
    shift_ctrl_pkg::ctrl_state_e state_q;
    shift_ctrl_pkg::ctrl_state_e state_d;
    logic                        armed_q;  // Low until the first edge after reset

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed_q <= 1'b0;
        end else begin
            armed_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= shift_ctrl_pkg::st_run;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            shift_ctrl_pkg::st_run: begin
                if (flush) begin
                    state_d = shift_ctrl_pkg::st_drain;
                end
            end
            shift_ctrl_pkg::st_drain: begin
                // All credits back means the pipeline and the FIFO are empty
                if (all_free) begin
                    state_d = shift_ctrl_pkg::st_ack;
                end
            end
            shift_ctrl_pkg::st_ack: begin
                state_d = shift_ctrl_pkg::st_run;
            end
            default: begin
                state_d = shift_ctrl_pkg::st_run;
            end
        endcase
    end

    assign in_ready   = armed_q && (state_q == shift_ctrl_pkg::st_run) && has_credit;
    assign flush_done = (state_q == shift_ctrl_pkg::st_ack);  // One-cycle pulse

endmodule

//--- source/log_barrel_shifter.sv
// Pipelined logarithmic barrel shifter, one register stage per shift-amount bit
`timescale 1ns/1ns

module log_barrel_shifter #(
    parameter int DATA_W = 16
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  shift_types_pkg::data_t     in_data,
    input  shift_types_pkg::shamt_t    in_shamt,
    input  shift_types_pkg::shift_op_e in_op,
    output logic                       res_valid,
    output shift_types_pkg::data_t     res_data
);
    localparam int STAGES = $clog2(DATA_W);

    // Index 0 is the input register, index k+1 the output of shift level k
    logic                       valid_q   [0:STAGES];
    shift_types_pkg::data_t     word_q    [0:STAGES];
    shift_types_pkg::shift_op_e op_q      [0:STAGES];
    shift_types_pkg::shamt_t    amt_q     [0:STAGES-1];  // Remaining amount, LSB is next level
    logic                       fill_q    [0:STAGES-1];  // Sign fill for sra
    shift_types_pkg::data_t     level_out [0:STAGES-1];

    function automatic shift_types_pkg::data_t bit_rev(input shift_types_pkg::data_t w);
        shift_types_pkg::data_t r;
        for (int i = 0; i < DATA_W; i++) begin
            r[i] = w[DATA_W-1-i];
        end
        return r;
    endfunction

    function automatic logic is_right(input shift_types_pkg::shift_op_e op);
        return (op == shift_types_pkg::op_srl) || (op == shift_types_pkg::op_sra);
    endfunction

    // Valid bits walk beside the data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k <= STAGES; k++) begin
                valid_q[k] <= 1'b0;
            end
        end else begin
            valid_q[0] <= in_valid;
            for (int k = 1; k <= STAGES; k++) begin
                valid_q[k] <= valid_q[k-1];
            end
        end
    end

    // Each level shifts left by 0 or 2**k
    always_comb begin
        int sh;
        for (int k = 0; k < STAGES; k++) begin
            sh = 1 << k;
            if (!amt_q[k][0]) begin
                level_out[k] = word_q[k];
            end else if (op_q[k] == shift_types_pkg::op_rol) begin
                level_out[k] = (word_q[k] << sh) | (word_q[k] >> (DATA_W - sh));  // Wrapped bits
            end else if (fill_q[k]) begin
                level_out[k] = (word_q[k] << sh) | shift_types_pkg::data_t'((1 << sh) - 1);
            end else begin
                level_out[k] = word_q[k] << sh;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            word_q[0] <= is_right(in_op) ? bit_rev(in_data) : in_data;
            op_q[0]   <= in_op;
            amt_q[0]  <= in_shamt;
            fill_q[0] <= (in_op == shift_types_pkg::op_sra) && in_data[DATA_W-1];
        end
        for (int k = 0; k < STAGES; k++) begin
            if (valid_q[k]) begin
                word_q[k+1] <= level_out[k];
                op_q[k+1]   <= op_q[k];
            end
        end
        for (int k = 1; k < STAGES; k++) begin
            if (valid_q[k-1]) begin
                amt_q[k]  <= amt_q[k-1] >> 1;
                fill_q[k] <= fill_q[k-1];
            end
        end
    end

    assign res_valid = valid_q[STAGES];
    // Undo the input reversal for right shifts
    assign res_data  = is_right(op_q[STAGES]) ? bit_rev(word_q[STAGES]) : word_q[STAGES];

endmodule

//--- source/result_fifo.sv
// Show-ahead result FIFO, holds shifter results until the consumer pops them
`timescale 1ns/1ns

module result_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_valid,
    input  shift_types_pkg::data_t wr_data,
    output logic                   out_valid,
    output shift_types_pkg::data_t out_data,
    input  logic                   out_ready
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

    shift_types_pkg::data_t  mem [0:FIFO_DEPTH-1];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    shift_ctrl_pkg::credit_t count;  // Entries held
    logic                    pop;

    // Depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    assign pop = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle, or write and pop together
            endcase
        end
    end

    // Head entry is visible while the FIFO holds anything
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

endmodule

//--- source/shift_ctrl_pkg.sv
// Control path types for the shift unit: issue FSM states and credit count
package shift_ctrl_pkg;

    // Issue FSM states
    typedef enum logic [1:0] {
        st_run   = 2'd0,  // Accepting commands
        st_drain = 2'd1,  // Flush pending, port closed
        st_ack   = 2'd2   // Flush complete, one cycle
    } ctrl_state_e;

    // Count of result FIFO slots, FIFO depth up to 16
    typedef logic [4:0] credit_t;

endpackage

//--- source/shift_types_pkg.sv
// Datapath types for the shift unit: data word, shift amount and shift operation
package shift_types_pkg;

    // Data word carried through the shifter and the result FIFO
    typedef logic [15:0] data_t;

    // Shift amount, one bit per shifter stage
    typedef logic [3:0] shamt_t;

    // Shift operation
    // Right shifts are done as left shifts on a bit-reversed word
    typedef enum logic [1:0] {
        op_sll = 2'd0,  // Logical left, zero fill
        op_srl = 2'd1,  // Logical right, zero fill
        op_sra = 2'd2,  // Arithmetic right, sign fill
        op_rol = 2'd3   // Rotate left
    } shift_op_e;

endpackage

//--- source/shift_unit_top.sv
// Shift unit top level, command port, pipelined shifter, result FIFO and flush control
`timescale 1ns/1ns

module shift_unit_top #(
    parameter int DATA_W     = 16,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // Command port
    input  logic                       in_valid,
    input  shift_types_pkg::data_t     in_data,
    input  shift_types_pkg::shamt_t    in_shamt,
    input  shift_types_pkg::shift_op_e in_op,
    output logic                       in_ready,
    // Result port
    output logic                       out_valid,
    output shift_types_pkg::data_t     out_data,
    input  logic                       out_ready,
    // Flush handshake
    input  logic                       flush,
    output logic                       flush_done
);
    logic                   accept;  // Command transfer
    logic                   pop;     // Result transfer
    logic                   has_credit;
    logic                   all_free;
    logic                   res_valid;
    shift_types_pkg::data_t res_data;

    assign accept = in_valid && in_ready;
    assign pop    = out_valid && out_ready;

    issue_fsm u_issue_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .has_credit (has_credit),
        .all_free   (all_free),
        .in_ready   (in_ready),
        .flush_done (flush_done)
    );

    credit_counter #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_credit_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .take       (accept),
        .give       (pop),
        .has_credit (has_credit),
        .all_free   (all_free)
    );

    log_barrel_shifter #(
        .DATA_W (DATA_W)
    ) u_shifter (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (accept),
        .in_data   (in_data),
        .in_shamt  (in_shamt),
        .in_op     (in_op),
        .res_valid (res_valid),
        .res_data  (res_data)
    );

    // No full flag, credits keep the FIFO from overflowing
    result_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_result_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_valid  (res_valid),
        .wr_data   (res_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule

//--- verification/shift_checker.sv
// Reference model and port protocol checks for the shift unit
`timescale 1ns/1ns

module shift_checker #(
    parameter int DATA_W     = 16,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic                       in_ready,
    input  shift_types_pkg::data_t     in_data,
    input  shift_types_pkg::shamt_t    in_shamt,
    input  shift_types_pkg::shift_op_e in_op,
    input  logic                       out_valid,
    input  logic                       out_ready,
    input  shift_types_pkg::data_t     out_data,
    input  logic                       flush,
    input  logic                       flush_done,
    input  logic                       fixed_latency,  // High while out_ready is held high
    input  logic                       test_end,
    output int                         value_errors,
    output int                         other_errors,
    output int                         accepted,
    output int                         popped
);
    localparam int STAGES  = $clog2(DATA_W);
    localparam int LATENCY = STAGES + 2;  // Acceptance edge to pop edge

    shift_types_pkg::data_t exp_q   [$];
    logic [21:0]            src_q   [$];  // {op, shamt, data}
    int                     cyc_q   [$];
    bit                     timed_q [$];
    bit                     seen    [0:3][0:15];  // Op by shift amount
    bit                     draining;
    bit                     end_done;
    int                     cycle;
    int                     lat;
    int                     missing;
    shift_types_pkg::data_t exp_val;
    logic [21:0]            src;

    // Bitwise model taking result bit i from source bit i-n or i+n, or filling it
    function automatic shift_types_pkg::data_t expected_shift(
        input shift_types_pkg::data_t    d,
        input shift_types_pkg::shamt_t   amt,
        input shift_types_pkg::shift_op_e op
    );
        shift_types_pkg::data_t r;
        int                     n;
        n = int'(amt);
        for (int i = 0; i < DATA_W; i++) begin
            case (op)
                shift_types_pkg::op_sll: r[i] = (i >= n) ? d[i-n] : 1'b0;
                shift_types_pkg::op_srl: r[i] = (i + n < DATA_W) ? d[i+n] : 1'b0;
                shift_types_pkg::op_sra: r[i] = (i + n < DATA_W) ? d[i+n] : d[DATA_W-1];
                default:                 r[i] = d[(i - n + DATA_W) % DATA_W];  // Rotate
            endcase
        end
        return r;
    endfunction

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want, input string note);
        $display("error: %s = 0x%0h, expected 0x%0h%s at %0t ns", name, got, want, note, $time);
        value_errors++;
    endtask

    task automatic protocol_failure(input string msg);
        $display("Check failed at %0t ns: %s", $time, msg);
        other_errors++;
    endtask

    initial begin
        value_errors = 0;
        other_errors = 0;
        accepted     = 0;
        popped       = 0;
        cycle        = 0;
        draining     = 1'b0;
        end_done     = 1'b0;
        for (int o = 0; o < 4; o++) begin
            for (int a = 0; a < 16; a++) begin
                seen[o][a] = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (!rst_n) begin
            if (in_ready !== 1'b0) value_mismatch("in_ready", 32'(in_ready), 0, " in reset");
            if (out_valid !== 1'b0) value_mismatch("out_valid", 32'(out_valid), 0, " in reset");
            if (flush_done !== 1'b0) value_mismatch("flush_done", 32'(flush_done), 0, " in reset");
        end else begin
            if (out_valid && accepted == 0) begin
                protocol_failure("out_valid rose before any command was accepted");
            end
            // Flush window checks on pre-edge state
            if (flush_done) begin
                if (!draining) begin
                    protocol_failure("flush_done without a pending flush request");
                end
                if (exp_q.size() != 0) begin
                    protocol_failure($sformatf("flush_done with %0d results outstanding",
                                               exp_q.size()));
                end
                if (out_valid) value_mismatch("out_valid", 32'(out_valid), 0, " at flush_done");
                draining = 1'b0;
            end else if (draining && in_ready) begin
                protocol_failure("in_ready high while a flush was draining");
            end
            if (out_valid && out_ready) begin
                popped++;
                if (exp_q.size() == 0) begin
                    protocol_failure("result popped with no command outstanding");
                end else begin
                    exp_val = exp_q.pop_front();
                    src     = src_q.pop_front();
                    lat     = cycle - cyc_q.pop_front();
                    if (out_data !== exp_val) begin
                        value_mismatch("out_data", 32'(out_data), 32'(exp_val),
                                       $sformatf(" (op %0d, shamt %0d, data 0x%h)",
                                                 src[21:20], src[19:16], src[15:0]));
                    end
                    if (timed_q.pop_front() && fixed_latency && lat != LATENCY) begin
                        protocol_failure($sformatf("result took %0d cycles instead of %0d",
                                                   lat, LATENCY));
                    end
                end
            end
            if (in_valid && in_ready) begin
                accepted++;
                exp_q.push_back(expected_shift(in_data, in_shamt, in_op));
                src_q.push_back({in_op, in_shamt, in_data});
                cyc_q.push_back(cycle);
                timed_q.push_back(fixed_latency);
                seen[in_op][in_shamt] = 1'b1;
            end
            if (accepted > popped + FIFO_DEPTH) begin
                protocol_failure($sformatf("%0d accepted but only %0d popped", accepted, popped));
            end
            if (flush && !flush_done) draining = 1'b1;
        end
        if (test_end && !end_done) begin
            end_done = 1'b1;
            if (exp_q.size() != 0) begin
                protocol_failure($sformatf("%0d results never came out", exp_q.size()));
            end
            missing = 0;
            for (int o = 0; o < 4; o++) begin
                for (int a = 0; a < 16; a++) begin
                    if (!seen[o][a]) missing++;
                end
            end
            if (missing != 0) begin
                protocol_failure($sformatf("%0d op and amount pairs never exercised", missing));
            end
        end
    end

endmodule

//--- verification/tb_shift_unit.sv
// Shift unit testbench, random commands with back-pressure and periodic flushes
`timescale 1ns/1ns

module tb_shift_unit;
    localparam int          DATA_W         = 16;
    localparam int          FIFO_DEPTH     = 8;
    localparam int          NUM_CMDS       = 2000;
    localparam int          FLUSH_EVERY    = 250;
    localparam int          TIMEOUT_CYCLES = NUM_CMDS * 20 + 500;
    localparam logic [31:0] SEED           = 32'hd5ff_2fc2;

    logic                       clk;
    logic                       rst_n;
    logic                       in_valid;
    shift_types_pkg::data_t     in_data;
    shift_types_pkg::shamt_t    in_shamt;
    shift_types_pkg::shift_op_e in_op;
    logic                       in_ready;
    logic                       out_valid;
    shift_types_pkg::data_t     out_data;
    logic                       out_ready;
    logic                       flush;
    logic                       flush_done;
    logic                       fixed_latency;  // First block runs without back-pressure
    logic                       test_end;
    int                         value_errors;
    int                         other_errors;
    int                         accepted;
    int                         popped;
    int                         tb_errors;
    int                         cycle_count;

    shift_unit_top #(
        .DATA_W     (DATA_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_shamt   (in_shamt),
        .in_op      (in_op),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_ready  (out_ready),
        .flush      (flush),
        .flush_done (flush_done)
    );

    shift_checker #(
        .DATA_W     (DATA_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_data       (in_data),
        .in_shamt      (in_shamt),
        .in_op         (in_op),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_data      (out_data),
        .flush         (flush),
        .flush_done    (flush_done),
        .fixed_latency (fixed_latency),
        .test_end      (test_end),
        .value_errors  (value_errors),
        .other_errors  (other_errors),
        .accepted      (accepted),
        .popped        (popped)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int         sent;
        int         next_flush;
        int         flushes;
        int         hold_left;
        bit         offering;
        bit         timed_phase;
        logic [1:0] op_bits;
        void'($urandom(SEED));
        sent          = 0;
        next_flush    = FLUSH_EVERY;
        flushes       = 0;
        hold_left     = 0;
        offering      = 1'b0;
        timed_phase   = 1'b1;
        tb_errors     = 0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_data       = '0;
        in_shamt      = '0;
        in_op         = shift_types_pkg::op_sll;
        out_ready     = 1'b1;
        flush         = 1'b0;
        fixed_latency = 1'b1;
        test_end      = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        while (flushes < NUM_CMDS / FLUSH_EVERY) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                sent++;
                offering = 1'b0;
            end
            if (flush && flush_done) begin
                flush <= 1'b0;
                flushes++;
                timed_phase = 1'b0;  // Back-pressure from the second block on
            end else if (!flush && sent >= next_flush) begin
                flush <= 1'b1;  // Held until acknowledged
                next_flush += FLUSH_EVERY;
            end
            fixed_latency <= timed_phase;
            if (!offering) begin
                if (sent < NUM_CMDS && $urandom_range(3) != 0) begin
                    op_bits = 2'($urandom);
                    in_valid <= 1'b1;
                    in_data  <= shift_types_pkg::data_t'($urandom);
                    in_shamt <= shift_types_pkg::shamt_t'($urandom);
                    in_op    <= shift_types_pkg::shift_op_e'(op_bits);
                    offering = 1'b1;
                end else begin
                    in_valid <= 1'b0;
                end
            end
            if (timed_phase) begin
                out_ready <= 1'b1;
            end else if (hold_left > 0) begin
                out_ready <= 1'b0;
                hold_left--;
            end else if ($urandom_range(63) == 0) begin
                hold_left = 8 + int'($urandom_range(31));  // Long stall
                out_ready <= 1'b0;
            end else begin
                out_ready <= ($urandom_range(3) != 0);
            end
        end
        in_valid <= 1'b0;
        test_end <= 1'b1;
        repeat (2) @(posedge clk);
        if (accepted != NUM_CMDS) begin
            $display("Only %0d of %0d commands were accepted", accepted, NUM_CMDS);
            tb_errors++;
        end
        $display("Errors: %0d data, %0d other, %0d testbench; %0d accepted, %0d popped",
                 value_errors, other_errors, tb_errors, accepted, popped);
        if (value_errors + other_errors + tb_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
